/* include/rsa_defs.svh */
`ifndef RSA_DEFS_SVH
`define RSA_DEFS_SVH

// ====================
// Operand geometry
// ====================

// Width of X, E, N and the result
`define RSA_OPERAND_BITS 16

// Bus bytes per operand, low byte first
`define RSA_OPERAND_BYTES 2

// Exponent bits consumed per run
`define RSA_EXP_BITS 16

// ====================
// Register map
// ====================

`define RSA_ADDR_CTRL 1'b0
`define RSA_ADDR_DATA 1'b1

`endif

/* logic/rsa_pkg.sv */
`include "rsa_defs.svh"

package rsa_pkg;

  typedef logic [7:0]                     byte_t;
  typedef logic [`RSA_OPERAND_BITS-1:0]   operand_t;
  typedef logic [0:0]                     byte_idx_t;
  typedef logic [4:0]                     bit_idx_t;

  // Control register at address 0
  typedef struct packed {
    logic [1:0] rsvd;
    logic       ready;
    logic       read_u;
    logic       load_n;
    logic       load_e;
    logic       load_x;
    logic       start;
  } ctrl_reg_t;

  // User operands as loaded over the bus
  typedef struct packed {
    operand_t x;
    operand_t e;
    operand_t n;
  } operands_t;

  typedef enum logic [2:0] {
    IDLE,
    MULT,
    MULT_WAIT,
    SQUARE,
    SQUARE_WAIT,
    NEXT_BIT
  } rsa_state_t;

endpackage

/* logic/mod_mult.sv */
`timescale 1ns/1ps
`include "rsa_defs.svh"

module mod_mult import rsa_pkg::*; (
  input  logic     clk,
  input  logic     reset_data_n,
  input  logic     start_i,
  input  operand_t a_i,
  input  operand_t b_i,
  input  operand_t n_i,
  output logic     done_o,
  output operand_t product_o
);

  operand_t a_q;
  operand_t b_q;
  operand_t n_q;
  operand_t acc_q;
  operand_t a_sel;
  operand_t n_sel;
  operand_t acc_sel;
  logic     b_bit;
  logic     busy_q;
  logic [$clog2(`RSA_OPERAND_BITS)-1:0] step_q;
  logic [`RSA_OPERAND_BITS+1:0] sum;
  logic [`RSA_OPERAND_BITS+1:0] red1;
  logic [`RSA_OPERAND_BITS+1:0] red2;

  // ====================
  // One interleaved step
  // ====================

  // First bit is taken straight from the inputs on start
  always_comb begin
    a_sel   = start_i ? a_i : a_q;
    n_sel   = start_i ? n_i : n_q;
    acc_sel = start_i ? '0 : acc_q;
    b_bit   = start_i ? b_i[`RSA_OPERAND_BITS-1] : b_q[`RSA_OPERAND_BITS-1];

    // 2*acc + a stays below 3n
    sum  = {1'b0, acc_sel, 1'b0} + (b_bit ? {2'b00, a_sel} : '0);
    red1 = (sum >= {2'b00, n_sel}) ? sum - {2'b00, n_sel} : sum;
    red2 = (red1 >= {2'b00, n_sel}) ? red1 - {2'b00, n_sel} : red1;
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      a_q   <= a_i;
      n_q   <= n_i;
      b_q   <= b_i << 1;
      acc_q <= red2[`RSA_OPERAND_BITS-1:0];
    end else if (busy_q) begin
      b_q   <= b_q << 1;
      acc_q <= red2[`RSA_OPERAND_BITS-1:0];
    end
  end

  // Done lands 16 cycles after start
  always_ff @(posedge clk) begin
    if (!reset_data_n) begin
      busy_q <= 1'b0;
      step_q <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        step_q <= 1'b1;
      end else if (busy_q) begin
        step_q <= step_q + 1'b1;
        if (step_q == $bits(step_q)'(`RSA_OPERAND_BITS - 1)) begin
          busy_q <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  assign product_o = acc_q;

endmodule

/* logic/rsa_regs.sv */
`timescale 1ns/1ps
`include "rsa_defs.svh"

module rsa_regs import rsa_pkg::*; (
  input  logic      clk,
  input  logic      reset_data_n,
  input  byte_t     data_i,
  input  logic      addr_i,
  input  logic      valid_i,
  input  logic      write_i,
  input  logic      ready_i,
  input  operand_t  result_i,
  output byte_t     data_o,
  output operands_t operands_o,
  output logic      start_o
);

  ctrl_reg_t ctrl_q;
  ctrl_reg_t ctrl_wr;
  ctrl_reg_t ctrl_rd;
  byte_idx_t byte_idx_q;
  logic      access;
  logic      ctrl_write;
  logic      data_write;
  logic      ctrl_read;
  logic      data_read;
  logic      idx_clear;
  logic      idx_step;
  logic      load_one;
  logic [2:0] load_sel;
  logic [3:0] mode_new;
  logic [3:0] mode_old;
  logic [$bits(byte_idx_t)+2:0] bit_base;

  // ====================
  // Bus decode
  // ====================

  // Nothing is accepted while the engine runs
  assign access     = valid_i && ready_i;
  assign ctrl_write = access && write_i && (addr_i == `RSA_ADDR_CTRL);
  assign data_write = access && write_i && (addr_i == `RSA_ADDR_DATA);
  assign ctrl_read  = access && !write_i && (addr_i == `RSA_ADDR_CTRL);
  assign data_read  = access && !write_i && (addr_i == `RSA_ADDR_DATA);

  // Ready and reserved bits are not stored
  always_comb begin
    ctrl_wr       = ctrl_reg_t'(data_i);
    ctrl_wr.rsvd  = '0;
    ctrl_wr.ready = 1'b0;
  end

  // Readback shows the live ready flag
  always_comb begin
    ctrl_rd       = ctrl_q;
    ctrl_rd.ready = ready_i;
  end

  // ====================
  // Byte index
  // ====================

  assign mode_new = {ctrl_wr.read_u, ctrl_wr.load_n, ctrl_wr.load_e, ctrl_wr.load_x};
  assign mode_old = {ctrl_q.read_u, ctrl_q.load_n, ctrl_q.load_e, ctrl_q.load_x};

  // Any rising mode bit restarts at the low byte
  assign idx_clear = ctrl_write && |(mode_new & ~mode_old);

  assign load_sel = {ctrl_q.load_n, ctrl_q.load_e, ctrl_q.load_x};
  assign load_one = (load_sel == 3'b001) || (load_sel == 3'b010) || (load_sel == 3'b100);
  assign idx_step = (data_write && load_one) || (data_read && ctrl_q.read_u);
  assign bit_base = {byte_idx_q, 3'b000};

  always_ff @(posedge clk) begin
    if (!reset_data_n) begin
      ctrl_q     <= '0;
      start_o    <= 1'b0;
      byte_idx_q <= '0;
      data_o     <= '0;
    end else begin
      // Start bit becomes a one cycle pulse
      start_o <= ctrl_q.start;
      if (ctrl_q.start) begin
        ctrl_q.start <= 1'b0;
      end
      if (ctrl_write) begin
        ctrl_q <= ctrl_wr;
      end

      if (idx_clear) begin
        byte_idx_q <= '0;
      end else if (idx_step) begin
        byte_idx_q <= byte_idx_q + 1'b1;
      end

      // data_o only moves on a read
      if (ctrl_read) begin
        data_o <= ctrl_rd;
      end else if (data_read) begin
        if (ctrl_q.read_u) begin
          data_o <= result_i[bit_base +: $bits(byte_t)];
        end else begin
          data_o <= '0;
        end
      end
    end
  end

  // ====================
  // Operand registers
  // ====================

  // Ignored unless exactly one load bit is set
  always_ff @(posedge clk) begin
    if (data_write) begin
      case (load_sel)
        3'b001: operands_o.x[bit_base +: $bits(byte_t)] <= data_i;
        3'b010: operands_o.e[bit_base +: $bits(byte_t)] <= data_i;
        3'b100: operands_o.n[bit_base +: $bits(byte_t)] <= data_i;
        default: ;
      endcase
    end
  end

endmodule

/* logic/rsa_ctrl.sv */
`timescale 1ns/1ps
`include "rsa_defs.svh"

module rsa_ctrl import rsa_pkg::*; (
  input  logic      clk,
  input  logic      reset_data_n,
  input  logic      start_i,
  input  operands_t operands_i,
  input  logic      mult_done_i,
  input  operand_t  mult_product_i,
  output logic      ready_o,
  output operand_t  result_o,
  output logic      mult_start_o,
  output operand_t  mult_a_o,
  output operand_t  mult_b_o,
  output operand_t  mult_n_o
);

  rsa_state_t state_q;
  rsa_state_t state_d;
  operand_t   p_q;
  operand_t   z_q;
  operand_t   e_q;
  bit_idx_t   bit_cnt_q;
  logic       launch;
  logic       last_bit;

  assign launch   = (state_q == IDLE) && start_i;
  assign last_bit = (bit_cnt_q == bit_idx_t'(`RSA_EXP_BITS - 1));

  // ====================
  // State machine
  // ====================

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // e_q is still loading, so look at the input
        if (start_i) begin
          state_d = operands_i.e[0] ? MULT : SQUARE;
        end
      end
      MULT: begin
        state_d = MULT_WAIT;
      end
      MULT_WAIT: begin
        if (mult_done_i) begin
          state_d = SQUARE;
        end
      end
      SQUARE: begin
        state_d = SQUARE_WAIT;
      end
      SQUARE_WAIT: begin
        if (mult_done_i) begin
          state_d = NEXT_BIT;
        end
      end
      NEXT_BIT: begin
        // Shift happens on this edge, next bit is e_q[1]
        if (last_bit) begin
          state_d = IDLE;
        end else begin
          state_d = e_q[1] ? MULT : SQUARE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_data_n) begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (launch) begin
        bit_cnt_q <= '0;
      end else if (state_q == NEXT_BIT) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  // ====================
  // P, Z and exponent
  // ====================

  always_ff @(posedge clk) begin
    if (launch) begin
      p_q <= operand_t'(1);
      z_q <= operands_i.x;
      e_q <= operands_i.e;
    end else begin
      case (state_q)
        MULT_WAIT: begin
          if (mult_done_i) begin
            p_q <= mult_product_i;
          end
        end
        SQUARE_WAIT: begin
          if (mult_done_i) begin
            z_q <= mult_product_i;
          end
        end
        NEXT_BIT: begin
          e_q <= e_q >> 1;
        end
        default: ;
      endcase
    end
  end

  // Outputs
  assign ready_o      = (state_q == IDLE);
  assign result_o     = p_q;
  assign mult_start_o = (state_q == MULT) || (state_q == SQUARE);

  // P*Z while multiplying, Z*Z while squaring
  assign mult_a_o = ((state_q == MULT) || (state_q == MULT_WAIT)) ? p_q : z_q;
  assign mult_b_o = z_q;
  assign mult_n_o = operands_i.n;

endmodule

/* logic/rsa_top.sv */
`timescale 1ns/1ps
`include "rsa_defs.svh"

module rsa_top import rsa_pkg::*; (
  input  logic  clk,
  input  logic  reset_data_n,
  input  byte_t data_i,
  output byte_t data_o,
  input  logic  addr_i,
  input  logic  valid_i,
  input  logic  write_i
);

  operands_t operands;
  operand_t  result;
  operand_t  mult_a;
  operand_t  mult_b;
  operand_t  mult_n;
  operand_t  mult_product;
  logic      start;
  logic      ready;
  logic      mult_start;
  logic      mult_done;

  // ====================
  // Register port
  // ====================

  rsa_regs u_regs (
    .clk          (clk),
    .reset_data_n (reset_data_n),
    .data_i       (data_i),
    .addr_i       (addr_i),
    .valid_i      (valid_i),
    .write_i      (write_i),
    .ready_i      (ready),
    .result_i     (result),
    .data_o       (data_o),
    .operands_o   (operands),
    .start_o      (start)
  );

  // ====================
  // Exponentiation core
  // ====================

  rsa_ctrl u_ctrl (
    .clk            (clk),
    .reset_data_n   (reset_data_n),
    .start_i        (start),
    .operands_i     (operands),
    .mult_done_i    (mult_done),
    .mult_product_i (mult_product),
    .ready_o        (ready),
    .result_o       (result),
    .mult_start_o   (mult_start),
    .mult_a_o       (mult_a),
    .mult_b_o       (mult_b),
    .mult_n_o       (mult_n)
  );

  mod_mult u_mult (
    .clk          (clk),
    .reset_data_n (reset_data_n),
    .start_i      (mult_start),
    .a_i          (mult_a),
    .b_i          (mult_b),
    .n_i          (mult_n),
    .done_o       (mult_done),
    .product_o    (mult_product)
  );

endmodule

/* verif/rsa_ctrl_chk.sv */
`timescale 1ns/1ps

module rsa_ctrl_chk import rsa_pkg::*; (
  input logic       clk,
  input logic       reset_data_n,
  input rsa_state_t state_q,
  input logic       start_i,
  input logic       ready_o,
  input logic       mult_start_o,
  input logic       mult_done_i
);

  // A new product never launches while the last one is returning
  a_start_not_pending: assert property (@(posedge clk) disable iff (!reset_data_n)
    mult_start_o |-> !mult_done_i)
    else $error("mult_start_o raised while mult_done_i was high");

  a_busy_not_ready: assert property (@(posedge clk) disable iff (!reset_data_n)
    start_i |=> !ready_o)
    else $error("ready_o still high the cycle after a start pulse");

  // No product can be pending once the run is over
  a_no_done_idle: assert property (@(posedge clk) disable iff (!reset_data_n)
    (state_q == IDLE) |-> !mult_done_i)
    else $error("mult_done_i arrived while the FSM is idle");

endmodule

bind rsa_ctrl rsa_ctrl_chk u_ctrl_chk (
  .clk          (clk),
  .reset_data_n (reset_data_n),
  .state_q      (state_q),
  .start_i      (start_i),
  .ready_o      (ready_o),
  .mult_start_o (mult_start_o),
  .mult_done_i  (mult_done_i)
);

/* verif/rsa_tb.sv */
`timescale 1ns/1ps
`include "rsa_defs.svh"

module rsa_tb import rsa_pkg::*; ();

  localparam byte_t CTRL_START  = 8'h01;
  localparam byte_t CTRL_LOAD_X = 8'h02;
  localparam byte_t CTRL_LOAD_E = 8'h04;
  localparam byte_t CTRL_LOAD_N = 8'h08;
  localparam byte_t CTRL_READ_U = 8'h10;
  localparam int    POLL_LIMIT  = 400;

  logic   clk;
  logic   reset_data_n;
  byte_t  data_i;
  byte_t  data_o;
  logic   addr_i;
  logic   valid_i;
  logic   write_i;
  integer seed;
  int     mismatch_count;
  int     timeout_count;

  rsa_top UUT (
    .clk          (clk),
    .reset_data_n (reset_data_n),
    .data_i       (data_i),
    .data_o       (data_o),
    .addr_i       (addr_i),
    .valid_i      (valid_i),
    .write_i      (write_i)
  );

  always #4 clk = ~clk;

  // ====================
  // Compare tasks
  // ====================

  task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %02h got %02h", $time, name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_operand(input string name, input operand_t expected,
                               input operand_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %04h got %04h", $time, name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_ctrl(input string name, input ctrl_reg_t expected,
                            input ctrl_reg_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %02h got %02h", $time, name, expected, actual);
      mismatch_count++;
    end
  endtask

  // Reference: right-to-left square and multiply, LSB of E first
  function automatic operand_t model_exp(input operands_t ops);
    logic [63:0] p;
    logic [63:0] z;
    p = 64'd1;
    z = {48'd0, ops.x};
    for (int i = 0; i < `RSA_EXP_BITS; i++) begin
      if (ops.e[i]) begin
        p = (p * z) % ops.n;
      end
      z = (z * z) % ops.n;
    end
    return operand_t'(p);
  endfunction

  // Expected control readback when idle
  function automatic ctrl_reg_t idle_ctrl(input byte_t mode_bits);
    ctrl_reg_t value;
    value       = ctrl_reg_t'(mode_bits);
    value.ready = 1'b1;
    return value;
  endfunction

  // ====================
  // Bus tasks
  // ====================

  task automatic write_reg(input logic addr, input byte_t data);
    @(posedge clk);
    #1;
    valid_i = 1'b1;
    write_i = 1'b1;
    addr_i  = addr;
    data_i  = data;
    @(posedge clk);
    #1;
    valid_i = 1'b0;
    write_i = 1'b0;
  endtask

  task automatic read_reg(input logic addr, output byte_t data);
    @(posedge clk);
    #1;
    valid_i = 1'b1;
    write_i = 1'b0;
    addr_i  = addr;
    @(posedge clk);
    #1;
    valid_i = 1'b0;
    @(posedge clk);
    #1;
    data = data_o;
  endtask

  task automatic load_operands(input operands_t ops);
    operand_t values [3];
    byte_t    selects [3];
    values  = '{ops.x, ops.e, ops.n};
    selects = '{CTRL_LOAD_X, CTRL_LOAD_E, CTRL_LOAD_N};
    for (int k = 0; k < 3; k++) begin
      // Clear first so the load bit sees a rising edge
      write_reg(`RSA_ADDR_CTRL, 8'h00);
      write_reg(`RSA_ADDR_CTRL, selects[k]);
      for (int i = 0; i < `RSA_OPERAND_BYTES; i++) begin
        write_reg(`RSA_ADDR_DATA, values[k][8*i +: 8]);
      end
    end
  endtask

  task automatic start_engine(input byte_t mode_bits);
    byte_t cleared;
    write_reg(`RSA_ADDR_CTRL, 8'h00);
    // Zero data_o so ignored status reads show ready low
    read_reg(`RSA_ADDR_DATA, cleared);
    check_byte("data_o", 8'h00, cleared);
    write_reg(`RSA_ADDR_CTRL, mode_bits | CTRL_START);
    // Start pulse, then the FSM leaves IDLE
    repeat (2) @(posedge clk);
  endtask

  task automatic wait_ready(output ctrl_reg_t status);
    byte_t raw;
    int    polls;
    polls  = 0;
    status = '0;
    while (!status.ready && polls < POLL_LIMIT) begin
      read_reg(`RSA_ADDR_CTRL, raw);
      status = ctrl_reg_t'(raw);
      polls++;
    end
    if (!status.ready) begin
      $display("Timeout at %0t: engine still busy after %0d status reads", $time, polls);
      timeout_count++;
    end
  endtask

  task automatic read_result(output operand_t value);
    byte_t b;
    write_reg(`RSA_ADDR_CTRL, 8'h00);
    write_reg(`RSA_ADDR_CTRL, CTRL_READ_U);
    for (int i = 0; i < `RSA_OPERAND_BYTES; i++) begin
      read_reg(`RSA_ADDR_DATA, b);
      value[8*i +: 8] = b;
    end
  endtask

  task automatic run_case(input operands_t ops, input operand_t expected);
    ctrl_reg_t status;
    operand_t  got;
    load_operands(ops);
    start_engine(8'h00);
    wait_ready(status);
    check_ctrl("ctrl", idle_ctrl(8'h00), status);
    read_result(got);
    check_operand("result", expected, got);
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    operands_t ops;
    ctrl_reg_t status;
    operand_t  got;
    operand_t  expected;
    byte_t     rd;
    seed           = 32'h8b59;
    mismatch_count = 0;
    timeout_count  = 0;
    clk            = 1'b0;
    reset_data_n   = 1'b0;
    data_i         = '0;
    addr_i         = 1'b0;
    valid_i        = 1'b0;
    write_i        = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset_data_n = 1'b1;

    // Reset state
    check_byte("data_o", 8'h00, data_o);
    read_reg(`RSA_ADDR_CTRL, rd);
    check_ctrl("ctrl", idle_ctrl(8'h00), ctrl_reg_t'(rd));

    // Directed corner cases
    run_case('{x: 16'h1234, e: 16'h0000, n: 16'hc351}, 16'h0001);
    run_case('{x: 16'h0bad, e: 16'h0001, n: 16'hfff1}, 16'h0bad);
    run_case('{x: 16'h0000, e: 16'h0013, n: 16'h7fff}, 16'h0000);
    run_case('{x: 16'h0001, e: 16'h1234, n: 16'h0002}, 16'h0001);

    for (int k = 0; k < 40; k++) begin
      ops.n = operand_t'($random(seed));
      if (ops.n < 16'd2) begin
        ops.n = ops.n + 16'd2;
      end
      ops.x = operand_t'($random(seed)) % ops.n;
      ops.e = operand_t'($random(seed));
      run_case(ops, model_exp(ops));
    end

    // Start has cleared, read_u still set from readback
    read_reg(`RSA_ADDR_CTRL, rd);
    check_ctrl("ctrl", idle_ctrl(CTRL_READ_U), ctrl_reg_t'(rd));

    // Reserved bits are dropped on write
    write_reg(`RSA_ADDR_CTRL, 8'hc0 | CTRL_READ_U);
    read_reg(`RSA_ADDR_CTRL, rd);
    check_ctrl("ctrl", idle_ctrl(CTRL_READ_U), ctrl_reg_t'(rd));

    // Data writes while busy must not reach X
    ops = '{x: 16'h2d41, e: 16'h8a35, n: 16'hf00d};
    expected = model_exp(ops);
    load_operands(ops);
    start_engine(CTRL_LOAD_X);
    write_reg(`RSA_ADDR_DATA, ~ops.x[7:0]);
    write_reg(`RSA_ADDR_DATA, ~ops.x[15:8]);
    wait_ready(status);
    check_ctrl("ctrl", idle_ctrl(CTRL_LOAD_X), status);
    read_result(got);
    check_operand("result", expected, got);
    start_engine(8'h00);
    wait_ready(status);
    read_result(got);
    check_operand("result", expected, got);
    ops = '{x: 16'h0456, e: 16'h3c07, n: 16'h9e3b};
    run_case(ops, model_exp(ops));

    // Partial readback, then a new read_u edge restarts at the low byte
    expected = model_exp(ops);
    read_reg(`RSA_ADDR_DATA, rd);
    check_byte("data_o", expected[7:0], rd);
    write_reg(`RSA_ADDR_CTRL, 8'h00);
    write_reg(`RSA_ADDR_CTRL, CTRL_READ_U);
    read_reg(`RSA_ADDR_DATA, rd);
    check_byte("data_o", expected[7:0], rd);
    read_result(got);
    check_operand("result", expected, got);

    $display("Summary: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
logic/rsa_pkg.sv
logic/mod_mult.sv
logic/rsa_regs.sv
logic/rsa_ctrl.sv
logic/rsa_top.sv
verif/rsa_ctrl_chk.sv
verif/rsa_tb.sv

/* Makefile */
TOP := rsa_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: build
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only --timing --assert -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
